// ==== hw/draw_pkg.sv ====
/* shared types for the drawing engine: coordinates, colour, addresses
   framebuffer size, register map and the FSM state enums */
`default_nettype none

package draw_pkg;

    typedef logic signed [15:0] coord_t;    // signed screen coordinate
    typedef logic [7:0]         color_t;    // pixel colour
    typedef logic [14:0]        fb_addr_t;  // linear framebuffer address
    typedef logic [2:0]         reg_addr_t; // host register index

    // visible screen size
    localparam int FB_WIDTH  = 160;  // pixels per row
    localparam int FB_HEIGHT = 120;  // rows

    // host register map
    localparam reg_addr_t REG_X0    = 3'd0;  // corner 0 column
    localparam reg_addr_t REG_Y0    = 3'd1;  // corner 0 row
    localparam reg_addr_t REG_X1    = 3'd2;  // corner 1 column
    localparam reg_addr_t REG_Y1    = 3'd3;  // corner 1 row
    localparam reg_addr_t REG_COLOR = 3'd4;  // outline colour
    localparam reg_addr_t REG_CTRL  = 3'd5;  // any write starts a draw

    typedef enum logic [1:0] {
        LINE_IDLE,  // waiting for start
        LINE_INIT,  // load position and error term
        LINE_DRAW   // one pixel per enabled cycle
    } line_state_t;

    typedef enum logic [1:0] {
        RECT_IDLE,  // waiting for start
        RECT_INIT,  // load endpoints of next edge
        RECT_DRAW   // edge line running
    } rect_state_t;

endpackage

`default_nettype wire

// ==== hw/draw_ifs.sv ====
/* shape_cmd_if: corners, colour and start from the register block
   pixel_if: pixel stream from the rectangle sequencer */
`timescale 1ns/1ps
`default_nettype none

interface shape_cmd_if import draw_pkg::*; ();
    logic   start;  // one-cycle pulse
    coord_t x0;     // corner 0
    coord_t y0;
    coord_t x1;     // opposite corner
    coord_t y1;
    color_t color;  // stable while busy

    modport host   (output start, x0, y0, x1, y1, color);
    modport engine (input  start, x0, y0, x1, y1, color);
endinterface

interface pixel_if import draw_pkg::*; ();
    coord_t x;        // pixel column
    coord_t y;        // pixel row
    logic   drawing;  // x and y valid this cycle
    logic   done;     // pulse after the last pixel of the shape

    modport source (output x, y, drawing, done);
    modport sink   (input  x, y, drawing, done);
endinterface

`default_nettype wire

// ==== hw/draw_line.sv ====
/* Bresenham line stepper, all octants, both endpoints drawn
   one pixel per cycle with oe high */
`timescale 1ns/1ps
`default_nettype none

module draw_line import draw_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start,    // begin a new line
    input  wire logic   oe,       // low freezes the stepper
    input  wire coord_t x0,       // start point
    input  wire coord_t y0,
    input  wire coord_t x1,       // end point
    input  wire coord_t y1,
    output coord_t      x,        // current position
    output coord_t      y,
    output logic        drawing,  // x and y hold a pixel
    output logic        done      // cycle after the last pixel
);

    // error term needs headroom beyond a coordinate for the doubled value
    typedef logic signed [$bits(coord_t)+1:0] err_t;

    line_state_t state;
    coord_t      xa, ya;       // latched start point
    coord_t      xb, yb;       // latched end point
    logic        right;        // step x upwards
    logic        down;         // step y upwards
    err_t        err;          // Bresenham error
    err_t        dx;           // |x1 - x0|
    err_t        dy;           // -|y1 - y0|
    err_t        e2;           // doubled error
    logic        movx, movy;   // step decisions
    logic        last;         // at end point

    always_comb begin
        dx   = right ? err_t'(xb) - err_t'(xa) : err_t'(xa) - err_t'(xb);
        dy   = down  ? err_t'(ya) - err_t'(yb) : err_t'(yb) - err_t'(ya);
        e2   = err <<< 1;
        movx = (e2 >= dy);
        movy = (e2 <= dx);
    end

    assign last    = (x == xb) && (y == yb);
    assign drawing = (state == LINE_DRAW) && oe;  // stalled cycles show no pixel

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LINE_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LINE_IDLE: if (start) state <= LINE_INIT;
                LINE_INIT: state <= LINE_DRAW;  // setup cycle
                LINE_DRAW: begin
                    if (oe && last) begin  // end point drawn this cycle
                        state <= LINE_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= LINE_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            LINE_IDLE: begin
                if (start) begin
                    xa    <= x0;
                    ya    <= y0;
                    xb    <= x1;
                    yb    <= y1;
                    right <= (x0 < x1);
                    down  <= (y0 < y1);
                end
            end
            LINE_INIT: begin
                x   <= xa;
                y   <= ya;
                err <= dx + dy;
            end
            LINE_DRAW: begin
                if (oe && !last) begin  // hold position when stalled
                    if (movx) x <= right ? x + coord_t'(1) : x - coord_t'(1);
                    if (movy) y <= down  ? y + coord_t'(1) : y - coord_t'(1);
                    err <= err + (movx ? dy : err_t'(0)) + (movy ? dx : err_t'(0));
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/draw_rectangle.sv ====
/* rectangle sequencer: walks top, right, bottom and left edges
   through one draw_line, corners drawn twice */
`timescale 1ns/1ps
`default_nettype none

module draw_rectangle import draw_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic oe,   // stall from memory side
    shape_cmd_if.engine cmd,  // corners and start
    pixel_if.source     pix   // pixel stream out
);

    rect_state_t state;
    logic [1:0]  edge_id;     // 0 top, 1 right, 2 bottom, 3 left
    logic        line_start;  // pulse into line stepper
    logic        line_done;   // edge finished
    coord_t      lx0, ly0;    // edge start point
    coord_t      lx1, ly1;    // edge end point

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RECT_IDLE;
            edge_id    <= 2'd0;
            line_start <= 1'b0;
            pix.done   <= 1'b0;
        end else begin
            line_start <= 1'b0;
            pix.done   <= 1'b0;
            case (state)
                RECT_IDLE: begin
                    if (cmd.start) begin  // start elsewhere is dropped
                        edge_id <= 2'd0;
                        state   <= RECT_INIT;
                    end
                end
                RECT_INIT: begin
                    line_start <= 1'b1;
                    state      <= RECT_DRAW;
                end
                RECT_DRAW: begin
                    if (line_done) begin
                        if (edge_id == 2'd3) begin  // fourth edge complete
                            pix.done <= 1'b1;
                            state    <= RECT_IDLE;
                        end else begin
                            edge_id <= edge_id + 2'd1;
                            state   <= RECT_INIT;
                        end
                    end
                end
                default: state <= RECT_IDLE;
            endcase
        end
    end

    // edge endpoints, clockwise from corner 0
    always_ff @(posedge clk) begin
        if (state == RECT_INIT) begin
            case (edge_id)
                2'd0: begin lx0 <= cmd.x0; ly0 <= cmd.y0; lx1 <= cmd.x1; ly1 <= cmd.y0; end
                2'd1: begin lx0 <= cmd.x1; ly0 <= cmd.y0; lx1 <= cmd.x1; ly1 <= cmd.y1; end
                2'd2: begin lx0 <= cmd.x1; ly0 <= cmd.y1; lx1 <= cmd.x0; ly1 <= cmd.y1; end
                default: begin
                    lx0 <= cmd.x0;  // left edge back up
                    ly0 <= cmd.y1;
                    lx1 <= cmd.x0;
                    ly1 <= cmd.y0;
                end
            endcase
        end
    end

    draw_line i_draw_line (
        .clk     (clk),
        .rst     (rst),
        .start   (line_start),
        .oe      (oe),
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (pix.x),
        .y       (pix.y),
        .drawing (pix.drawing),
        .done    (line_done)
    );

endmodule

`default_nettype wire

// ==== hw/draw_regs.sv ====
/* host register block: corners, colour, start pulse and busy flag */
`timescale 1ns/1ps
`default_nettype none

module draw_regs import draw_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        reg_we,     // host write strobe
    input  wire reg_addr_t   reg_addr,   // register index
    input  wire logic [15:0] reg_wdata,  // write data
    shape_cmd_if.host        cmd,        // to sequencer and writer
    pixel_if.sink            pix,        // done ends the draw
    output logic             busy        // draw in progress
);

    logic ctrl_wr;  // write to control register

    assign ctrl_wr = reg_we && (reg_addr == REG_CTRL);

    // start pulse and busy tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.start <= 1'b0;
            busy      <= 1'b0;
        end else begin
            cmd.start <= ctrl_wr;  // one cycle, sequencer filters repeats
            if (ctrl_wr) begin
                busy <= 1'b1;
            end else if (pix.done) begin
                busy <= 1'b0;
            end
        end
    end

    // shape parameters, frozen during a draw
    always_ff @(posedge clk) begin
        if (reg_we && !busy) begin
            case (reg_addr)
                REG_X0:    cmd.x0    <= coord_t'(reg_wdata);
                REG_Y0:    cmd.y0    <= coord_t'(reg_wdata);
                REG_X1:    cmd.x1    <= coord_t'(reg_wdata);
                REG_Y1:    cmd.y1    <= coord_t'(reg_wdata);
                REG_COLOR: cmd.color <= reg_wdata[$bits(color_t)-1:0];  // low byte
                default: ;  // control handled above
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/fb_writer.sv ====
/* framebuffer writer: clip to screen, linear address, registered write
   also delays done behind the last write */
`timescale 1ns/1ps
`default_nettype none

module fb_writer import draw_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    shape_cmd_if.engine cmd,      // colour only
    pixel_if.sink       pix,      // pixel stream in
    output logic        fb_we,    // write strobe
    output fb_addr_t    fb_addr,  // row * width + column
    output color_t      fb_data,  // pixel colour
    output logic        done      // follows final write
);

    logic     visible;   // pixel lands on screen
    fb_addr_t pix_addr;  // linear address of current pixel

    always_comb begin
        visible = pix.drawing
            && (pix.x >= 0) && (pix.x < FB_WIDTH)
            && (pix.y >= 0) && (pix.y < FB_HEIGHT);
    end

    // only meaningful when visible, so truncation is safe
    assign pix_addr = fb_addr_t'(pix.y) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(pix.x);

    // strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            fb_we <= 1'b0;
            done  <= 1'b0;
        end else begin
            fb_we <= visible;   // off-screen pixels dropped
            done  <= pix.done;  // one cycle behind, like the writes
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (visible) begin
            fb_addr <= pix_addr;
            fb_data <= cmd.color;
        end
    end

endmodule

`default_nettype wire

// ==== hw/draw_top.sv ====
/* top level: register block, rectangle sequencer and framebuffer writer
   host and memory sides as plain ports */
`timescale 1ns/1ps
`default_nettype none

module draw_top import draw_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        reg_we,     // host register write
    input  wire reg_addr_t   reg_addr,
    input  wire logic [15:0] reg_wdata,
    input  wire logic        oe,         // memory side ready
    output logic             busy,       // drawing in progress
    output logic             done,       // shape finished, one cycle
    output logic             fb_we,      // framebuffer write
    output fb_addr_t         fb_addr,
    output color_t           fb_data
);

    shape_cmd_if cmd ();  // regs to engine
    pixel_if     pix ();  // sequencer to writer

    draw_regs i_draw_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .cmd       (cmd.host),
        .pix       (pix.sink),
        .busy      (busy)
    );

    draw_rectangle i_draw_rectangle (
        .clk (clk),
        .rst (rst),
        .oe  (oe),
        .cmd (cmd.engine),
        .pix (pix.source)
    );

    fb_writer i_fb_writer (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd.engine),
        .pix     (pix.sink),
        .fb_we   (fb_we),
        .fb_addr (fb_addr),
        .fb_data (fb_data),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== sim/draw_chk.sv ====
/* concurrent assertions on the draw_top outputs
   bound into every draw_top instance */
`timescale 1ns/1ps
`default_nettype none

module draw_chk import draw_pkg::*; (
    input wire logic     clk,
    input wire logic     rst,
    input wire logic     oe,
    input wire logic     busy,
    input wire logic     done,
    input wire logic     fb_we,
    input wire fb_addr_t fb_addr
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200 pixels

    addr_in_range: assert property (@(posedge clk) disable iff (rst)
        fb_we |-> (int'(fb_addr) < FB_PIXELS))
        else $error("framebuffer write beyond the last pixel");

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held for more than one cycle");

    // busy clears on the internal done, one cycle ahead of the top-level done
    done_after_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(busy))
        else $error("done without a draw in progress");

    // a stalled cycle carries no pixel, so the next cycle has no write
    no_write_after_stall: assert property (@(posedge clk) disable iff (rst)
        !oe |=> !fb_we)
        else $error("framebuffer write in the cycle after oe low");

endmodule

bind draw_top draw_chk i_draw_chk (
    .clk     (clk),
    .rst     (rst),
    .oe      (oe),
    .busy    (busy),
    .done    (done),
    .fb_we   (fb_we),
    .fb_addr (fb_addr)
);

`default_nettype wire

// ==== sim/draw_tb.sv ====
/* testbench for draw_top with clock, LFSR stimulus, register write tasks,
   expected-write model per rectangle and output checks */
`timescale 1ns/1ps
`default_nettype none

module draw_tb import draw_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;  // covers the longest outline plus a stall
    localparam int NUM_RANDOM     = 30;

    logic        clk;
    logic        rst;
    logic        reg_we;
    reg_addr_t   reg_addr;
    logic [15:0] reg_wdata;
    logic        oe;
    logic        busy;
    logic        done;
    logic        fb_we;
    fb_addr_t    fb_addr;
    color_t      fb_data;

    logic [31:0] lfsr;           // random state
    int          exp_cnt [int];  // expected writes per address
    int          remaining;      // writes still outstanding
    int          cur_x0, cur_y0; // corners as programmed
    int          cur_x1, cur_y1;
    int          cur_color;
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;

    draw_top i_draw_top (
        .clk       (clk),
        .rst       (rst),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .oe        (oe),
        .busy      (busy),
        .done      (done),
        .fb_we     (fb_we),
        .fb_addr   (fb_addr),
        .fb_data   (fb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns
    end

    // taps of x^32 + x^22 + x^2 + x + 1
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic int rand_coord();
        return rand_bits(8) % 200 - 20;  // range -20 to 179 so edges get clipped
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        err_cnt++;
        $display("ERROR %0t %s", $time, what);
    endtask

    // one visible pixel adds one expected write
    task automatic add_pixel(input int x, input int y);
        int a;
        if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT) begin
            a          = y * FB_WIDTH + x;
            exp_cnt[a] = exp_cnt.exists(a) ? exp_cnt[a] + 1 : 1;
            remaining++;
        end
    endtask

    task automatic add_edge(input int ax, input int ay, input int bx, input int by);
        int sx;
        int sy;
        int n;
        sx = (bx > ax) ? 1 : (bx < ax) ? -1 : 0;
        sy = (by > ay) ? 1 : (by < ay) ? -1 : 0;
        n  = (sx != 0) ? (bx - ax) * sx : (by - ay) * sy;  // edges are axis aligned
        for (int i = 0; i <= n; i++) begin
            add_pixel(ax + i * sx, ay + i * sy);  // both endpoints included
        end
    endtask

    task automatic build_model();
        exp_cnt.delete();
        remaining = 0;
        add_edge(cur_x0, cur_y0, cur_x1, cur_y0);  // top
        add_edge(cur_x1, cur_y0, cur_x1, cur_y1);  // right
        add_edge(cur_x1, cur_y1, cur_x0, cur_y1);  // bottom
        add_edge(cur_x0, cur_y1, cur_x0, cur_y0);  // left edge back to corner 0
    endtask

    // call just after a rising edge and return after the sampling edge
    task automatic write_reg(input reg_addr_t a, input logic [15:0] d);
        reg_we    <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_we    <= 1'b0;
    endtask

    task automatic program_rect(input int x0, input int y0, input int x1, input int y1,
                                input int c);
        cur_x0    = x0;
        cur_y0    = y0;
        cur_x1    = x1;
        cur_y1    = y1;
        cur_color = c;
        write_reg(REG_X0, 16'(x0));
        write_reg(REG_Y0, 16'(y0));
        write_reg(REG_X1, 16'(x1));
        write_reg(REG_Y1, 16'(y1));
        write_reg(REG_COLOR, 16'(c));
    endtask

    task automatic program_random();
        int x0, y0;
        int x1, y1;
        int c;
        x0 = rand_coord();
        y0 = rand_coord();
        x1 = rand_coord();
        y1 = rand_coord();
        c  = rand_bits(8);
        program_rect(x0, y0, x1, y1, c);
    endtask

    task automatic idle_check(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            oe <= (rand_bits(2) != 0);
            @(negedge clk);
            check_val("busy", busy, 0);
            check_val("done", done, 0);
            check_val("fb_we", fb_we, 0);
            @(posedge clk);
        end
    endtask

    // start one rectangle and follow it to done and a short quiet tail
    task automatic run_draw(input string label, input int stall_at, input int stall_len,
                            input bit poke);
        int   k;
        int   a;
        int   writes;
        int   dones;
        int   tail;
        int   errs_before;
        logic oe_before;    // oe of the previous cycle
        logic busy_before;  // busy at the previous sample
        errs_before = err_cnt;
        writes      = 0;
        dones       = 0;
        tail        = 0;
        k           = 0;
        busy_before = 1'b0;
        build_model();
        write_reg(REG_CTRL, 16'd1);
        while (!(dones > 0 && tail >= 4) && k < TIMEOUT_CYCLES) begin
            oe_before = oe;
            if (stall_at > 0 && k >= stall_at && k < stall_at + stall_len) begin
                oe <= 1'b0;  // memory side blocked
            end else begin
                oe <= (rand_bits(2) != 0);  // high three cycles in four
            end
            if (poke) begin
                case (k)
                    2: begin
                        reg_we    <= 1'b1;
                        reg_addr  <= REG_X0;  // ignored while busy
                        reg_wdata <= 16'(cur_x0 + 7);
                    end
                    3: begin
                        reg_addr  <= REG_COLOR;
                        reg_wdata <= 16'(cur_color ^ 8'hff);
                    end
                    4: reg_we <= 1'b0;
                    default: ;
                endcase
            end
            @(negedge clk);
            if (!oe_before) begin
                check_val("fb_we after oe low", fb_we, 0);
            end
            if (fb_we) begin
                writes++;
                a = int'(fb_addr);
                check_val("fb_data", fb_data, cur_color);
                if (exp_cnt.exists(a) && exp_cnt[a] > 0) begin
                    exp_cnt[a]--;
                    remaining--;
                end else begin
                    report_problem($sformatf("%s wrote address %0d outside the outline",
                                             label, a));
                end
            end
            if (done) begin
                dones++;
                if (dones == 1) begin
                    check_val("writes left at done", remaining, 0);
                    check_val("busy at done", busy, 0);
                    check_val("busy before done", busy_before, 1);
                end else begin
                    report_problem($sformatf("%s gave a second done pulse", label));
                end
            end else if (dones > 0) begin
                tail++;
            end
            busy_before = busy;
            k++;
            @(posedge clk);
        end
        if (dones == 0) begin
            report_problem($sformatf("%s never signalled done", label));
            $display("Finished with errors");
            $finish;
        end else begin
            test_cnt++;
            $display("%s: (%0d,%0d)-(%0d,%0d) %0d writes in %0d cycles, %0d errors", label,
                     cur_x0, cur_y0, cur_x1, cur_y1, writes, k, err_cnt - errs_before);
        end
    endtask

    initial begin
        int stall;
        rst       = 1'b1;
        reg_we    = 1'b0;
        reg_addr  = REG_X0;
        reg_wdata = 16'd0;
        oe        = 1'b0;
        lfsr      = 32'h350c_bfd8;
        err_cnt   = 0;
        check_cnt = 0;
        test_cnt  = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // quiet after reset and after parameter writes alone
        idle_check(8);
        program_random();
        idle_check(8);
        test_cnt++;
        $display("reset: outputs idle until a control write, %0d errors", err_cnt);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            if (t > 0) begin
                program_random();
            end
            run_draw($sformatf("random rect %0d", t), 0, 0, 1'b0);
        end

        program_rect(-15, -5, -2, -19, 8'h3c);  // left of the screen
        run_draw("off screen left", 0, 0, 1'b0);
        program_rect(20, 125, 90, 170, 8'h5a);  // below the last row
        run_draw("off screen below", 0, 0, 1'b0);
        program_rect(-10, 100, 170, 130, 8'ha5);
        run_draw("partly off screen", 0, 0, 1'b0);

        program_random();
        run_draw("writes while busy", 0, 0, 1'b1);
        run_draw("restart with old values", 0, 0, 1'b0);

        program_rect(12, 9, 140, 100, 8'hc3);
        stall = 10 + rand_bits(5);
        run_draw($sformatf("oe low for %0d cycles", stall), 12, stall, 1'b0);

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/draw_pkg.sv
hw/draw_ifs.sv
hw/draw_line.sv
hw/draw_rectangle.sv
hw/draw_regs.sv
hw/fb_writer.sv
hw/draw_top.sv
sim/draw_chk.sv
sim/draw_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the drawing engine testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module draw_tb -Mdir obj_dir -f src.f

# the simulator exit code is not trusted, the log decides
./obj_dir/Vdraw_tb 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
